/* flist.f */
logic/mips_pkg.sv
logic/fetch_unit.sv
logic/instr_queue.sv
logic/register_file.sv
logic/alu.sv
logic/execute_unit.sv
logic/mips_core.sv
test/wb_imem_model.sv
test/tb_mips_core.sv

/* test/tb_mips_core.sv */
// ************************************************************
// Testbench for the MIPS subset core
// Clock, reset, Wishbone ROM model and shadow register file
// Concurrent assertions per behavior, reporting and timeout
// ************************************************************

`timescale 1ns/10ps

module tb_mips_core;
  import mips_pkg::*;

  localparam word_t PC_INIT      = 32'h0000_0000;
  localparam int    QUEUE_DEPTH  = 4;
  localparam int    PROG_LEN     = 40;
  localparam int    RESET_CYCLES = 16;
  localparam int    TAIL_CYCLES  = 20;
  localparam int    CYCLE_LIMIT  = RESET_CYCLES + 6 * PROG_LEN + 100;
  localparam int    NUM_TESTS    = 6;
  localparam int    DRIVE_DLY    = 1;

  logic     CLK;
  logic     nRST;
  wb_req_t  wb_req;
  wb_rsp_t  wb_rsp;
  retire_t  retire;
  logic     halt;

  // Shadow model state
  word_t    prog [PROG_LEN];
  word_t    shadow [32];
  int       prog_idx;
  logic     exp_valid;
  logic     exp_halt;
  logic     exp_rtype;
  regbits_t exp_wsel;
  word_t    exp_wdata;
  word_t    exp_fetch_adr;
  logic     seen_req;
  logic     halt_seen;

  // Bookkeeping
  int       cycle_cnt;
  int       retire_cnt;
  int       r_hits;
  int       i_hits;
  int       error_total;
  int       fails [1:NUM_TESTS];
  string    test_names [1:NUM_TESTS];

  mips_core #(
    .PC_INIT     (PC_INIT),
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) i_mips_core (
    .CLK      (CLK),
    .nRST     (nRST),
    .wb_req_o (wb_req),
    .wb_rsp_i (wb_rsp),
    .retire_o (retire),
    .halt_o   (halt)
  );

  wb_imem_model i_wb_imem_model (
    .CLK      (CLK),
    .nRST     (nRST),
    .wb_req_i (wb_req),
    .wb_rsp_o (wb_rsp)
  );

  // 100 ns period
  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  // ************************************************************
  // ISA reference
  // ************************************************************
  // Result of one instruction on the shadow registers
  function automatic void isa_result(input word_t ins, output logic wr,
                                     output regbits_t dst, output word_t val);
    word_t      a;
    word_t      b;
    word_t      simm;
    word_t      zimm;
    logic [4:0] sh;
    a    = shadow[ins[25:21]];
    b    = shadow[ins[20:16]];
    simm = {{16{ins[15]}}, ins[15:0]};
    zimm = {16'h0000, ins[15:0]};
    sh   = ins[10:6];
    wr   = 1'b1;
    dst  = ins[20:16];
    val  = '0;
    case (ins[31:26])
      RTYPE: begin
        dst = ins[15:11];
        case (ins[5:0])
          SLL:     val = b << sh;
          SRL:     val = b >> sh;
          ADDU:    val = a + b;
          SUBU:    val = a - b;
          AND:     val = a & b;
          OR:      val = a | b;
          XOR:     val = a ^ b;
          NOR:     val = ~(a | b);
          SLT:     val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          SLTU:    val = (a < b) ? 32'd1 : 32'd0;
          default: wr = 1'b0;
        endcase
      end
      ADDIU:   val = a + simm;
      SLTI:    val = ($signed(a) < $signed(simm)) ? 32'd1 : 32'd0;
      SLTIU:   val = (a < simm) ? 32'd1 : 32'd0;
      ANDI:    val = a & zimm;
      ORI:     val = a | zimm;
      XORI:    val = a ^ zimm;
      LUI:     val = {ins[15:0], 16'h0000};
      // Anything else is a no-op
      default: wr = 1'b0;
    endcase
  endfunction

  // Walk the program to the next instruction that must retire
  task automatic find_next_retire();
    logic     wr;
    regbits_t dst;
    word_t    val;
    exp_valid = 1'b0;
    while (!exp_valid && !exp_halt && prog_idx < PROG_LEN) begin
      if (prog[prog_idx][31:26] == HALT) begin
        exp_halt = 1'b1;
      end else begin
        isa_result(prog[prog_idx], wr, dst, val);
        // Register 0 writes and no-ops are skipped silently
        if (wr && dst != '0) begin
          exp_valid = 1'b1;
          exp_wsel  = dst;
          exp_wdata = val;
          exp_rtype = (prog[prog_idx][31:26] == RTYPE);
        end
        prog_idx++;
      end
    end
  endtask

  // Apply each matched retire to the shadow file
  always @(posedge CLK) begin
    if (nRST && retire.valid && exp_valid) begin
      shadow[exp_wsel] = exp_wdata;
      retire_cnt++;
      if (exp_rtype) r_hits++;
      else i_hits++;
      find_next_retire();
    end
    if (halt) halt_seen = 1'b1;
  end

  // Fetch address tracker
  always @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      exp_fetch_adr <= PC_INIT;
      seen_req      <= 1'b0;
    end else begin
      if (wb_req.stb) seen_req <= 1'b1;
      if (wb_req.stb && wb_rsp.ack) exp_fetch_adr <= exp_fetch_adr + 32'd4;
    end
  end

  // ************************************************************
  // Checks
  // ************************************************************
  // 1. Reset state
  reset_quiet: assert property (@(posedge CLK)
    !nRST |-> !wb_req.cyc && !wb_req.stb && !retire.valid && !halt)
    else begin
      fails[1]++;
      $display("Bus, retire or halt active during reset");
    end
  reset_release: assert property (@(posedge CLK)
    $rose(nRST) |-> !wb_req.cyc && !wb_req.stb && !retire.valid && !halt)
    else begin
      fails[1]++;
      $display("Bus, retire or halt active on the first cycle after reset");
    end
  first_adr: assert property (@(posedge CLK) disable iff (!nRST)
    (wb_req.stb && !seen_req) |-> wb_req.adr == PC_INIT)
    else begin
      fails[1]++;
      $display("CHECK FAILED wb_req_o.adr expected %h actual %h",
               PC_INIT, $sampled(wb_req.adr));
    end

  // 2. Wishbone discipline and fetch order
  adr_stable: assert property (@(posedge CLK) disable iff (!nRST)
    (wb_req.stb && !wb_rsp.ack) |=> wb_req.stb && $stable(wb_req.adr))
    else begin
      fails[2]++;
      $display("Request dropped or address moved before ack");
    end
  adr_step: assert property (@(posedge CLK) disable iff (!nRST)
    (wb_req.stb && wb_rsp.ack) |-> wb_req.adr == exp_fetch_adr)
    else begin
      fails[2]++;
      $display("CHECK FAILED wb_req_o.adr expected %h actual %h",
               $sampled(exp_fetch_adr), $sampled(wb_req.adr));
    end
  we_low: assert property (@(posedge CLK) disable iff (!nRST) !wb_req.we)
    else begin
      fails[2]++;
      $display("Write enable raised by a read-only master");
    end
  drop_after_ack: assert property (@(posedge CLK) disable iff (!nRST)
    (wb_req.stb && wb_rsp.ack) |=> !wb_req.cyc && !wb_req.stb)
    else begin
      fails[2]++;
      $display("cyc or stb still high in the cycle after ack");
    end

  // 3. R-type results
  r_wsel: assert property (@(posedge CLK) disable iff (!nRST)
    (retire.valid && exp_valid && exp_rtype) |-> retire.wsel == exp_wsel)
    else begin
      fails[3]++;
      $display("CHECK FAILED retire_o.wsel expected %h actual %h",
               $sampled(exp_wsel), $sampled(retire.wsel));
    end
  r_wdata: assert property (@(posedge CLK) disable iff (!nRST)
    (retire.valid && exp_valid && exp_rtype) |-> retire.wdata == exp_wdata)
    else begin
      fails[3]++;
      $display("CHECK FAILED retire_o.wdata expected %h actual %h",
               $sampled(exp_wdata), $sampled(retire.wdata));
    end

  // 4. Immediates
  i_wsel: assert property (@(posedge CLK) disable iff (!nRST)
    (retire.valid && exp_valid && !exp_rtype) |-> retire.wsel == exp_wsel)
    else begin
      fails[4]++;
      $display("CHECK FAILED retire_o.wsel expected %h actual %h",
               $sampled(exp_wsel), $sampled(retire.wsel));
    end
  i_wdata: assert property (@(posedge CLK) disable iff (!nRST)
    (retire.valid && exp_valid && !exp_rtype) |-> retire.wdata == exp_wdata)
    else begin
      fails[4]++;
      $display("CHECK FAILED retire_o.wdata expected %h actual %h",
               $sampled(exp_wdata), $sampled(retire.wdata));
    end

  // 5. Order and register 0
  order: assert property (@(posedge CLK) disable iff (!nRST)
    retire.valid |-> exp_valid)
    else begin
      fails[5]++;
      $display("Retire seen with no instruction left before HALT");
    end
  no_r0_retire: assert property (@(posedge CLK) disable iff (!nRST)
    retire.valid |-> retire.wsel != '0)
    else begin
      fails[5]++;
      $display("Write to register 0 was reported as a retire");
    end

  // 6. Halt
  halt_sticky: assert property (@(posedge CLK) disable iff (!nRST) halt |=> halt)
    else begin
      fails[6]++;
      $display("halt_o dropped after it was set");
    end
  halt_no_retire: assert property (@(posedge CLK) disable iff (!nRST)
    halt |-> !retire.valid)
    else begin
      fails[6]++;
      $display("retire_o.valid high after halt_o");
    end
  halt_last: assert property (@(posedge CLK) disable iff (!nRST)
    $rose(halt) |-> exp_halt)
    else begin
      fails[6]++;
      $display("halt_o rose before all earlier instructions retired");
    end
  halt_no_fetch: assert property (@(posedge CLK) disable iff (!nRST)
    (halt && !wb_req.stb) |=> !wb_req.stb)
    else begin
      fails[6]++;
      $display("New Wishbone request started after halt_o");
    end

  // ************************************************************
  // Run control
  // ************************************************************
  // Ends the run if HALT never arrives
  always @(posedge CLK) begin
    cycle_cnt++;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles without reaching HALT", cycle_cnt);
      $display("Simulation failed");
      $finish;
    end
  end

  // Reach checks, one line per test, then the totals
  task automatic print_report();
    int passed;
    int failed;
    passed      = 0;
    failed      = 0;
    error_total = 0;
    assert (seen_req) else begin
      fails[1]++;
      $display("No Wishbone request was ever made");
    end
    assert (exp_fetch_adr != PC_INIT) else begin
      fails[2]++;
      $display("No Wishbone read was ever acknowledged");
    end
    assert (r_hits > 0) else begin
      fails[3]++;
      $display("No R-type instruction retired");
    end
    assert (i_hits > 0) else begin
      fails[4]++;
      $display("No immediate instruction retired");
    end
    assert (exp_halt) else begin
      fails[5]++;
      $display("Only %0d retires seen before the run ended", retire_cnt);
    end
    assert (halt_seen) else begin
      fails[6]++;
      $display("halt_o never rose");
    end
    for (int t = 1; t <= NUM_TESTS; t++) begin
      if (fails[t] == 0) begin
        passed++;
        $display("Test %0d %s: PASS", t, test_names[t]);
      end else begin
        failed++;
        $display("Test %0d %s: FAIL with %0d errors", t, test_names[t], fails[t]);
      end
      error_total += fails[t];
    end
    $display("Tests passed %0d, failed %0d, errors %0d, retires %0d",
             passed, failed, error_total, retire_cnt);
  endtask

  initial begin
    void'($urandom(74));
    nRST          = 1'b1;
    cycle_cnt     = 0;
    retire_cnt    = 0;
    r_hits        = 0;
    i_hits        = 0;
    prog_idx      = 0;
    exp_valid     = 1'b0;
    exp_halt      = 1'b0;
    exp_rtype     = 1'b0;
    exp_wsel      = '0;
    exp_wdata     = '0;
    halt_seen     = 1'b0;
    test_names[1] = "reset state";
    test_names[2] = "Wishbone discipline";
    test_names[3] = "R-type results";
    test_names[4] = "immediates";
    test_names[5] = "order and register 0";
    test_names[6] = "halt";
    foreach (fails[i]) fails[i] = 0;
    foreach (shadow[i]) shadow[i] = '0;
    // Clean falling edge so the asynchronous reset acts at once
    #DRIVE_DLY nRST = 1'b0;
    foreach (prog[i]) prog[i] = i_wb_imem_model.rom[i];
    find_next_retire();
    repeat (RESET_CYCLES) @(posedge CLK);
    #DRIVE_DLY nRST = 1'b1;
    while (!halt) @(posedge CLK);
    // Watch the quiet period after HALT
    repeat (TAIL_CYCLES) @(posedge CLK);
    print_report();
    if (error_total == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* test/wb_imem_model.sv */
// ************************************************************
// Wishbone classic slave ROM for the core testbench
// Fixed test program of 40 words ending in HALT
// Random wait states, data driven only with ack
// ************************************************************

`timescale 1ns/10ps

module wb_imem_model (
  input  logic              CLK,
  input  logic              nRST,
  input  mips_pkg::wb_req_t wb_req_i,
  output mips_pkg::wb_rsp_t wb_rsp_o
);
  import mips_pkg::*;

  localparam int ROM_WORDS = 64;
  localparam int OUT_DLY   = 1;

  word_t      rom [ROM_WORDS];
  logic       ack_q    = 1'b0;
  logic       busy     = 1'b0;
  logic [1:0] wait_cnt = 2'd0;
  word_t      dat_q    = '0;
  wb_rsp_t    rsp_q    = '0;

  // R-type word, operands in assembly order
  function automatic word_t r_op(input funct_t fn, input regbits_t rd, input regbits_t rs,
                                 input regbits_t rt, input logic [4:0] sh);
    return {RTYPE, rs, rt, rd, sh, fn};
  endfunction

  // I-type word
  function automatic word_t i_op(input opcode_t op, input regbits_t rt, input regbits_t rs,
                                 input imm16_t imm);
    return {op, rs, rt, imm};
  endfunction

  // ************************************************************
  // Program
  // ************************************************************
  initial begin
    // Unused words decode as HALT, low bits carry the byte address
    for (int i = 0; i < ROM_WORDS; i++) begin
      rom[i] = {HALT, 26'(i * 4)};
    end
    // Operand setup, negative and zero-extended values
    rom[0]  = i_op(LUI, 1, 0, 16'h8000);
    rom[1]  = i_op(ORI, 1, 1, 16'h1234);
    rom[2]  = i_op(ADDIU, 2, 0, 16'hFFFB);
    rom[3]  = i_op(ADDIU, 3, 0, 16'h0064);
    rom[4]  = i_op(ORI, 4, 0, 16'hF0F0);
    // R-type arithmetic and logic
    rom[5]  = r_op(ADDU, 5, 2, 3, 0);
    rom[6]  = r_op(SUBU, 6, 3, 2, 0);
    rom[7]  = r_op(SUBU, 7, 2, 3, 0);
    rom[8]  = r_op(AND, 8, 1, 4, 0);
    rom[9]  = r_op(OR, 9, 1, 4, 0);
    rom[10] = r_op(XOR, 10, 1, 2, 0);
    rom[11] = r_op(NOR, 11, 3, 4, 0);
    // Signed vs unsigned compares
    rom[12] = r_op(SLT, 12, 2, 3, 0);
    rom[13] = r_op(SLT, 13, 3, 2, 0);
    rom[14] = r_op(SLTU, 14, 2, 3, 0);
    rom[15] = r_op(SLTU, 15, 3, 2, 0);
    // Shifts
    rom[16] = r_op(SLL, 16, 0, 1, 4);
    rom[17] = r_op(SRL, 17, 0, 1, 8);
    rom[18] = r_op(SLL, 18, 0, 2, 31);
    // Immediates, both extension kinds
    rom[19] = i_op(ADDIU, 19, 1, 16'h8000);
    rom[20] = i_op(SLTI, 20, 2, 16'hFFFF);
    rom[21] = i_op(SLTI, 21, 3, 16'h8000);
    rom[22] = i_op(SLTIU, 22, 3, 16'hFFFF);
    rom[23] = i_op(SLTIU, 23, 2, 16'h0005);
    rom[24] = i_op(ANDI, 24, 2, 16'hFF00);
    rom[25] = i_op(XORI, 25, 2, 16'h8001);
    rom[26] = i_op(ORI, 26, 3, 16'hFFFF);
    rom[27] = i_op(LUI, 27, 0, 16'hABCD);
    // Writes to register 0, then reads of it
    rom[28] = r_op(ADDU, 0, 3, 3, 0);
    rom[29] = i_op(ADDIU, 0, 0, 16'h0007);
    rom[30] = r_op(ADDU, 28, 0, 3, 0);
    rom[31] = r_op(OR, 29, 0, 0, 0);
    // Opcode and funct outside the subset
    rom[32] = 32'h0805_0010;
    rom[33] = 32'h0063_4808;
    rom[34] = r_op(ADDU, 30, 27, 26, 0);
    rom[35] = r_op(SUBU, 31, 0, 1, 0);
    rom[36] = r_op(XOR, 1, 1, 1, 0);
    rom[37] = r_op(SLT, 2, 31, 0, 0);
    rom[38] = i_op(ADDIU, 3, 3, 16'hFF9C);
    rom[39] = {HALT, 26'h0};
  end

  // ************************************************************
  // Bus response
  // ************************************************************
  // First cycle of a request draws 0 to 3 extra wait states
  always @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      ack_q    <= 1'b0;
      busy     <= 1'b0;
      wait_cnt <= 2'd0;
      dat_q    <= '0;
    end else begin
      ack_q <= 1'b0;
      if (wb_req_i.cyc && wb_req_i.stb && !ack_q) begin
        if (!busy) begin
          busy     <= 1'b1;
          wait_cnt <= 2'($urandom_range(3, 0));
        end else if (wait_cnt == 2'd0) begin
          busy  <= 1'b0;
          ack_q <= 1'b1;
          dat_q <= rom[wb_req_i.adr[7:2]];
        end else begin
          wait_cnt <= wait_cnt - 2'd1;
        end
      end
    end
  end

  // Response reaches the core a little after the edge
  always @(ack_q or dat_q) begin
    rsp_q <= #OUT_DLY {ack_q, (ack_q ? dat_q : 32'h0)};
  end

  assign wb_rsp_o = rsp_q;

endmodule

/* logic/mips_core.sv */
// ************************************************************
// MIPS subset core, top level
// Fetch unit feeds the instruction queue
// Execute unit drains it and reports retires
// ************************************************************

`timescale 1ns/10ps

module mips_core #(
  parameter mips_pkg::word_t PC_INIT     = '0,
  parameter int              QUEUE_DEPTH = 4
) (
  input  logic              CLK,
  input  logic              nRST,
  output mips_pkg::wb_req_t wb_req_o,
  input  mips_pkg::wb_rsp_t wb_rsp_i,
  output mips_pkg::retire_t retire_o,
  output logic              halt_o
);
  import mips_pkg::*;

  // Fetch to queue
  logic        push;
  fetch_item_t push_item;
  logic        full;

  // Queue to execute
  fetch_item_t head;
  logic        empty;
  logic        pop;

  // Halt from execute also stops new fetches
  fetch_unit #(
    .PC_INIT (PC_INIT)
  ) i_fetch_unit (
    .CLK         (CLK),
    .nRST        (nRST),
    .halt_i      (halt_o),
    .full_i      (full),
    .wb_req_o    (wb_req_o),
    .wb_rsp_i    (wb_rsp_i),
    .push_o      (push),
    .push_item_o (push_item)
  );

  instr_queue #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) i_instr_queue (
    .CLK         (CLK),
    .nRST        (nRST),
    .push_i      (push),
    .push_item_i (push_item),
    .pop_i       (pop),
    .head_o      (head),
    .full_o      (full),
    .empty_o     (empty)
  );

  execute_unit i_execute_unit (
    .CLK      (CLK),
    .nRST     (nRST),
    .head_i   (head),
    .empty_i  (empty),
    .pop_o    (pop),
    .retire_o (retire_o),
    .halt_o   (halt_o)
  );

endmodule

/* logic/execute_unit.sv */
// ************************************************************
// Execute unit
// Decode, immediate extension, register file and ALU
// Write-back select, registered retire report
// Sticky halt that stops further pops
// ************************************************************

`timescale 1ns/10ps

module execute_unit (
  input  logic                  CLK,
  input  logic                  nRST,
  input  mips_pkg::fetch_item_t head_i,
  input  logic                  empty_i,
  output logic                  pop_o,
  output mips_pkg::retire_t     retire_o,
  output logic                  halt_o
);
  import mips_pkg::*;

  // Instruction fields
  word_t    instr;
  opcode_t  opcode;
  funct_t   funct;
  regbits_t rs, rt, rd;
  logic [4:0] shamt;
  imm16_t   imm16;

  // Decode outputs
  aluop_t   aluop;
  logic     reg_dst;   // rd when set, else rt
  logic     alu_src;   // immediate on port B
  logic     sign_ext;
  logic     wb_upper;  // LUI result
  logic     reg_wr;
  logic     is_halt;

  // Datapath
  word_t    ext_imm, rdat1, rdat2, port_b, alu_out, wdata;
  regbits_t wsel;
  logic     halt_q;
  logic     retire_valid_q;
  regbits_t retire_wsel_q;
  word_t    retire_wdata_q;

  assign instr  = head_i.instr;
  assign opcode = opcode_t'(instr[31:26]);
  assign funct  = funct_t'(instr[5:0]);
  assign rs     = instr[25:21];
  assign rt     = instr[20:16];
  assign rd     = instr[15:11];
  assign shamt  = instr[10:6];
  assign imm16  = instr[15:0];

  // One instruction per cycle while work is queued
  assign pop_o = !empty_i && !halt_q;

  // ************************************************************
  // Decode
  // ************************************************************
  always_comb begin
    aluop    = ALU_ADD;
    reg_dst  = 1'b0;
    alu_src  = 1'b1;
    sign_ext = 1'b1;
    wb_upper = 1'b0;
    reg_wr   = 1'b0;
    is_halt  = 1'b0;
    case (opcode)
      RTYPE: begin
        reg_dst = 1'b1;
        alu_src = 1'b0;
        reg_wr  = 1'b1;
        case (funct)
          SLL:     aluop = ALU_SLL;
          SRL:     aluop = ALU_SRL;
          ADDU:    aluop = ALU_ADD;
          SUBU:    aluop = ALU_SUB;
          AND:     aluop = ALU_AND;
          OR:      aluop = ALU_OR;
          XOR:     aluop = ALU_XOR;
          NOR:     aluop = ALU_NOR;
          SLT:     aluop = ALU_SLT;
          SLTU:    aluop = ALU_SLTU;
          // Unknown funct is a no-op
          default: reg_wr = 1'b0;
        endcase
      end
      ADDIU: reg_wr = 1'b1;
      SLTI: begin
        aluop  = ALU_SLT;
        reg_wr = 1'b1;
      end
      SLTIU: begin
        aluop  = ALU_SLTU;
        reg_wr = 1'b1;
      end
      // Logic immediates zero-extend
      ANDI: begin
        aluop    = ALU_AND;
        sign_ext = 1'b0;
        reg_wr   = 1'b1;
      end
      ORI: begin
        aluop    = ALU_OR;
        sign_ext = 1'b0;
        reg_wr   = 1'b1;
      end
      XORI: begin
        aluop    = ALU_XOR;
        sign_ext = 1'b0;
        reg_wr   = 1'b1;
      end
      LUI: begin
        wb_upper = 1'b1;
        reg_wr   = 1'b1;
      end
      HALT:    is_halt = 1'b1;
      default: reg_wr = 1'b0;
    endcase
  end

  // ************************************************************
  // Operands and write-back
  // ************************************************************
  assign ext_imm = sign_ext ? {{16{imm16[15]}}, imm16} : {16'h0000, imm16};
  assign port_b  = alu_src ? ext_imm : rdat2;
  assign wsel    = reg_dst ? rd : rt;
  assign wdata   = wb_upper ? {imm16, 16'h0000} : alu_out;

  register_file i_register_file (
    .CLK     (CLK),
    .nRST    (nRST),
    .wen_i   (pop_o && reg_wr),
    .wsel_i  (wsel),
    .rsel1_i (rs),
    .rsel2_i (rt),
    .wdat_i  (wdata),
    .rdat1_o (rdat1),
    .rdat2_o (rdat2)
  );

  alu i_alu (
    .aluop_i  (aluop),
    .port_a_i (rdat1),
    .port_b_i (port_b),
    .shamt_i  (shamt),
    .out_o    (alu_out)
  );

  // ************************************************************
  // Retire and halt
  // ************************************************************
  // Writes to register 0 are not reported
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      retire_valid_q <= 1'b0;
      halt_q         <= 1'b0;
    end else begin
      retire_valid_q <= pop_o && reg_wr && (wsel != '0);
      if (pop_o && is_halt) halt_q <= 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    retire_wsel_q  <= wsel;
    retire_wdata_q <= wdata;
  end

  assign retire_o.valid = retire_valid_q;
  assign retire_o.wsel  = retire_wsel_q;
  assign retire_o.wdata = retire_wdata_q;
  assign halt_o         = halt_q;

  // Nothing retires once halted
  assert property (@(posedge CLK) disable iff (!nRST) halt_o |-> !retire_o.valid);

endmodule

/* logic/alu.sv */
// ************************************************************
// ALU
// Add, subtract, logic ops, set-less-than, logical shifts
// Purely combinational
// ************************************************************

`timescale 1ns/10ps

module alu (
  input  mips_pkg::aluop_t aluop_i,
  input  mips_pkg::word_t  port_a_i,
  input  mips_pkg::word_t  port_b_i,
  input  logic [4:0]       shamt_i,
  output mips_pkg::word_t  out_o
);
  import mips_pkg::*;

  always_comb begin
    case (aluop_i)
      // Shifts act on port B
      ALU_SLL:  out_o = port_b_i << shamt_i;
      ALU_SRL:  out_o = port_b_i >> shamt_i;
      // No overflow traps
      ALU_ADD:  out_o = port_a_i + port_b_i;
      ALU_SUB:  out_o = port_a_i - port_b_i;
      ALU_AND:  out_o = port_a_i & port_b_i;
      ALU_OR:   out_o = port_a_i | port_b_i;
      ALU_XOR:  out_o = port_a_i ^ port_b_i;
      ALU_NOR:  out_o = ~(port_a_i | port_b_i);
      // Compare results are 0 or 1
      ALU_SLT:  out_o = {31'b0, ($signed(port_a_i) < $signed(port_b_i))};
      ALU_SLTU: out_o = {31'b0, (port_a_i < port_b_i)};
      default:  out_o = '0;
    endcase
  end

endmodule

/* logic/register_file.sv */
// ************************************************************
// Register file
// 32 x 32-bit, two combinational reads, one write
// Register 0 always reads zero
// ************************************************************

`timescale 1ns/10ps

module register_file (
  input  logic               CLK,
  input  logic               nRST,
  input  logic               wen_i,
  input  mips_pkg::regbits_t wsel_i,
  input  mips_pkg::regbits_t rsel1_i,
  input  mips_pkg::regbits_t rsel2_i,
  input  mips_pkg::word_t    wdat_i,
  output mips_pkg::word_t    rdat1_o,
  output mips_pkg::word_t    rdat2_o
);
  import mips_pkg::*;

  word_t regs [32];

  // Writes to register 0 are dropped
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen_i && (wsel_i != '0)) begin
      regs[wsel_i] <= wdat_i;
    end
  end

  // Read ports, zero register forced
  assign rdat1_o = (rsel1_i == '0) ? '0 : regs[rsel1_i];
  assign rdat2_o = (rsel2_i == '0) ? '0 : regs[rsel2_i];

endmodule

/* logic/instr_queue.sv */
// ************************************************************
// Instruction queue
// Circular FIFO of fetched items between fetch and execute
// Same-cycle push and pop, full and empty flags
// ************************************************************

`timescale 1ns/10ps

module instr_queue #(
  parameter int QUEUE_DEPTH = 4
) (
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  push_i,
  input  mips_pkg::fetch_item_t push_item_i,
  input  logic                  pop_i,
  output mips_pkg::fetch_item_t head_o,
  output logic                  full_o,
  output logic                  empty_o
);
  import mips_pkg::*;

  // Depth is a power of two, pointers wrap on their own
  localparam int PTR_W = $clog2(QUEUE_DEPTH);

  fetch_item_t          mem [QUEUE_DEPTH];
  logic [PTR_W-1:0]     rd_ptr;
  logic [PTR_W-1:0]     wr_ptr;
  logic [PTR_W:0]       count;

  // ************************************************************
  // Storage
  // ************************************************************
  always_ff @(posedge CLK) begin
    if (push_i) begin
      mem[wr_ptr] <= push_item_i;
    end
  end

  // Pointers and occupancy
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_i) wr_ptr <= wr_ptr + 1'b1;
      if (pop_i)  rd_ptr <= rd_ptr + 1'b1;
      // Both at once leaves the count alone
      case ({push_i, pop_i})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Head visible the cycle after its push
  assign head_o  = mem[rd_ptr];
  assign full_o  = (count == (PTR_W + 1)'(QUEUE_DEPTH));
  assign empty_o = (count == '0);

  // Producer and consumer both respect the flags
  assert property (@(posedge CLK) disable iff (!nRST) push_i |-> !full_o);
  assert property (@(posedge CLK) disable iff (!nRST) pop_i |-> !empty_o);

endmodule

/* logic/fetch_unit.sv */
// ************************************************************
// Fetch unit
// PC register with PC+4 sequencing
// Wishbone classic read master, one request at a time
// Pushes each fetched word with its PC into the queue
// ************************************************************

`timescale 1ns/10ps

module fetch_unit #(
  parameter mips_pkg::word_t PC_INIT = '0
) (
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  halt_i,
  input  logic                  full_i,
  output mips_pkg::wb_req_t     wb_req_o,
  input  mips_pkg::wb_rsp_t     wb_rsp_i,
  output logic                  push_o,
  output mips_pkg::fetch_item_t push_item_o
);
  import mips_pkg::*;

  // Bus cycle state
  typedef enum logic {
    IDLE,
    REQ
  } state_t;

  state_t state, nxt_state;
  word_t  pc;
  logic   accept;

  // Word accepted on this edge
  assign accept = (state == REQ) && wb_rsp_i.ack;

  // ************************************************************
  // Bus FSM
  // ************************************************************
  always_comb begin
    nxt_state = state;
    case (state)
      // Start only with room in the queue and no halt
      IDLE: if (!full_i && !halt_i) nxt_state = REQ;
      // Hold until ack, then one idle cycle
      REQ:  if (wb_rsp_i.ack) nxt_state = IDLE;
      default: nxt_state = IDLE;
    endcase
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state <= IDLE;
    end else begin
      state <= nxt_state;
    end
  end

  // PC steps once per accepted word
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      pc <= PC_INIT;
    end else if (accept) begin
      pc <= pc + 32'd4;
    end
  end

  // ************************************************************
  // Outputs
  // ************************************************************
  // Read only, address is the current PC
  assign wb_req_o.cyc = (state == REQ);
  assign wb_req_o.stb = (state == REQ);
  assign wb_req_o.we  = 1'b0;
  assign wb_req_o.adr = pc;

  // Item goes into the queue on the ack edge
  assign push_o            = accept;
  assign push_item_o.pc    = pc;
  assign push_item_o.instr = wb_rsp_i.dat;

  // Request held with a steady address until the slave answers
  assert property (@(posedge CLK) disable iff (!nRST)
    (wb_req_o.stb && !wb_rsp_i.ack) |=> (wb_req_o.stb && $stable(wb_req_o.adr)));

  // Full check before the request keeps the queue from overflowing
  assert property (@(posedge CLK) disable iff (!nRST)
    push_o |-> !full_i);

endmodule

/* logic/mips_pkg.sv */
// ************************************************************
// Shared types for the MIPS subset core
// Widths, opcode and funct encodings, ALU operations
// Wishbone request and response bundles
// Queue item and retire report structs
// ************************************************************

package mips_pkg;

  // Basic widths
  typedef logic [31:0] word_t;
  typedef logic [4:0]  regbits_t;
  typedef logic [15:0] imm16_t;

  // ************************************************************
  // Instruction encodings
  // ************************************************************
  // Primary opcode, bits 31:26
  typedef enum logic [5:0] {
    RTYPE = 6'b000000,
    ADDIU = 6'b001001,
    SLTI  = 6'b001010,
    SLTIU = 6'b001011,
    ANDI  = 6'b001100,
    ORI   = 6'b001101,
    XORI  = 6'b001110,
    LUI   = 6'b001111,
    HALT  = 6'b111111
  } opcode_t;

  // R-type function field, bits 5:0
  typedef enum logic [5:0] {
    SLL  = 6'b000000,
    SRL  = 6'b000010,
    ADDU = 6'b100001,
    SUBU = 6'b100011,
    AND  = 6'b100100,
    OR   = 6'b100101,
    XOR  = 6'b100110,
    NOR  = 6'b100111,
    SLT  = 6'b101010,
    SLTU = 6'b101011
  } funct_t;

  // ALU operation select
  typedef enum logic [3:0] {
    ALU_SLL,
    ALU_SRL,
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_NOR,
    ALU_SLT,
    ALU_SLTU
  } aluop_t;

  // ************************************************************
  // Bundles
  // ************************************************************
  // Master to slave, 35 bits
  typedef struct packed {
    logic  cyc;
    logic  stb;
    logic  we;
    word_t adr;
  } wb_req_t;

  // Slave to master, 33 bits
  typedef struct packed {
    logic  ack;
    word_t dat;
  } wb_rsp_t;

  // Fetched word with its address
  typedef struct packed {
    word_t pc;
    word_t instr;
  } fetch_item_t;

  // One register write per retire
  typedef struct packed {
    logic     valid;
    regbits_t wsel;
    word_t    wdata;
  } retire_t;

endpackage
